//--- logic/pci_pkg.sv
package pci_pkg;

    // bus address and device address
    typedef logic [31:0] addr_t;

    // data word on ad and in target memory
    typedef logic [31:0] word_t;

    // memory word pointer, 0..MEM_WORDS-1
    typedef logic [3:0] ptr_t;

    // command on cbe during the address phase
    typedef enum logic [3:0] {
        cmd_read  = 4'b0000,
        cmd_write = 4'b1000    // msb set means write
    } cmd_e;

    // initiator FSM
    typedef enum logic [2:0] {
        init_idle,    // waiting for force_req
        init_req,     // req_n low, waiting for gnt_n and an idle bus
        init_addr,    // address phase, frame_n low
        init_data,    // data phase, irdy_n low
        init_turn     // turnaround, done or abort pulse
    } init_state_e;

    // words per target memory
    localparam int MEM_WORDS = 10;

    // data cycles without devsel_n before master abort
    localparam int ABORT_LIMIT = 4;

    // device i answers at DEV_ADDR_BASE + i
    localparam addr_t DEV_ADDR_BASE = 32'd16;

endpackage

//--- logic/pci_bus_if.sv
`timescale 1ns/1ps

// merged shared bus, one driver (central), everybody else listens
interface pci_bus_if import pci_pkg::*; ();

    logic  frame_n;     // address phase strobe
    logic  irdy_n;      // initiator ready
    logic  trdy_n;      // target ready
    logic  devsel_n;    // target claimed the address
    word_t ad;          // multiplexed address/data
    cmd_e  cbe;         // command, address phase only

    modport initiator (
        input frame_n, irdy_n, trdy_n, devsel_n, ad, cbe
    );

    modport target (
        input frame_n, irdy_n, trdy_n, devsel_n, ad, cbe
    );

    // AND/OR merge output
    modport central (
        output frame_n, irdy_n, trdy_n, devsel_n, ad, cbe
    );

endinterface

//--- logic/pci_init_if.sv
`timescale 1ns/1ps

// one initiator's drive towards the merge, plus its req/gnt pair
interface pci_init_if import pci_pkg::*; ();

    logic  frame_n;    // high when not driving
    logic  irdy_n;     // high when not driving
    addr_t ad;         // zero when not driving
    cmd_e  cbe;        // zero (cmd_read) when not driving
    logic  req_n;      // bus request to the arbiter
    logic  gnt_n;      // registered grant back

    modport initiator (
        output frame_n, irdy_n, ad, cbe, req_n,
        input  gnt_n
    );

    modport central (
        input  frame_n, irdy_n, ad, cbe, req_n,
        output gnt_n
    );

endinterface

//--- logic/pci_central.sv
`timescale 1ns/1ps

module pci_central import pci_pkg::*; #(
    parameter int NUM_DEV = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    pci_init_if.central        init [NUM_DEV],
    input  logic [NUM_DEV-1:0] tgt_trdy_n,
    input  logic [NUM_DEV-1:0] tgt_devsel_n,
    input  word_t              tgt_ad [NUM_DEV],
    pci_bus_if.central         bus,
    output logic [NUM_DEV-1:0] gnt_vec_n
);

    logic [NUM_DEV-1:0] req_vec_n;     // gathered req_n of all initiators
    logic [NUM_DEV-1:0] ini_frame_n;
    logic [NUM_DEV-1:0] ini_irdy_n;
    addr_t              ini_ad [NUM_DEV];
    logic [3:0]         ini_cbe [NUM_DEV];
    logic [NUM_DEV-1:0] gnt_next_n;
    logic               frame_all_n;   // merged strobes
    logic               irdy_all_n;
    logic               bus_idle;
    word_t              ad_or;
    logic [3:0]         cbe_or;

    // flatten the interface array so loops can walk it
    for (genvar g = 0; g < NUM_DEV; g++) begin : g_gather
        assign req_vec_n[g]   = init[g].req_n;
        assign ini_frame_n[g] = init[g].frame_n;
        assign ini_irdy_n[g]  = init[g].irdy_n;
        assign ini_ad[g]      = init[g].ad;
        assign ini_cbe[g]     = init[g].cbe;
        assign init[g].gnt_n  = gnt_vec_n[g];
    end

    // active-low strobes: AND, everything else: OR
    assign frame_all_n = &ini_frame_n;
    assign irdy_all_n  = &ini_irdy_n;
    assign bus_idle    = frame_all_n && irdy_all_n;   // no transaction in flight

    always_comb
    begin
        ad_or  = '0;
        cbe_or = '0;
        for (int i = 0; i < NUM_DEV; i++)
        begin
            ad_or  = ad_or | ini_ad[i] | tgt_ad[i];   // idle drivers give zero
            cbe_or = cbe_or | ini_cbe[i];
        end
    end

    assign bus.frame_n  = frame_all_n;
    assign bus.irdy_n   = irdy_all_n;
    assign bus.trdy_n   = &tgt_trdy_n;
    assign bus.devsel_n = &tgt_devsel_n;
    assign bus.ad       = ad_or;
    assign bus.cbe      = cmd_e'(cbe_or);

    // fixed priority, later index overwrites so highest index wins
    always_comb
    begin
        gnt_next_n = '1;    // nobody when nobody asks
        for (int i = 0; i < NUM_DEV; i++)
        begin
            if (!req_vec_n[i])
            begin
                gnt_next_n    = '1;
                gnt_next_n[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            gnt_vec_n <= '1;
        else if (bus_idle)          // grant parks while frame/irdy busy
            gnt_vec_n <= gnt_next_n;
    end

    // one owner at most
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~gnt_vec_n) <= 1);

endmodule

//--- logic/pci_initiator.sv
`timescale 1ns/1ps

module pci_initiator import pci_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          force_req,
    input  logic          rw,              // 1 write, 0 read
    input  addr_t         contact_addr,
    input  word_t         wdata,
    pci_bus_if.initiator  bus,
    pci_init_if.initiator port,
    output logic          done,
    output logic          abort,
    output word_t         rdata
);

    localparam int CNT_W = $clog2(ABORT_LIMIT);

    init_state_e      state;
    init_state_e      state_next;
    logic [CNT_W-1:0] wait_cnt;    // data cycles seen without a claim
    logic             aborted;     // last data phase timed out
    logic             bus_idle;
    logic             claimed;
    logic             timeout;
    addr_t            addr_q;      // latched target address
    logic             wr_q;        // latched direction
    word_t            wdata_q;     // latched write word
    cmd_e             cmd;

    assign bus_idle = bus.frame_n && bus.irdy_n;
    assign claimed  = !bus.devsel_n && !bus.trdy_n;   // target answered this cycle
    assign timeout  = (wait_cnt == CNT_W'(ABORT_LIMIT - 1));
    assign cmd      = wr_q ? cmd_write : cmd_read;

    always_comb
    begin
        state_next = state;
        case (state)
            init_idle: if (force_req) state_next = init_req;
            init_req:
            begin
                if (!port.gnt_n && bus_idle)    // granted and previous owner gone
                    state_next = init_addr;
            end
            init_addr: state_next = init_data;  // single address cycle
            init_data:
            begin
                if (claimed || timeout)
                    state_next = init_turn;
            end
            init_turn: state_next = init_idle;
            default:   state_next = init_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= init_idle;
            wait_cnt <= '0;
            aborted  <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (state == init_addr)
                wait_cnt <= '0;                // fresh abort timer per transfer
            else if (state == init_data && !claimed)
                wait_cnt <= wait_cnt + 1'b1;
            if (state == init_data)
                aborted <= !claimed;           // only matters on the way out
        end
    end

    // transaction payload captured on the way into the address phase
    always_ff @(posedge clk)
    begin
        if (state == init_req && state_next == init_addr)
        begin
            addr_q  <= contact_addr;
            wr_q    <= rw;
            wdata_q <= wdata;
        end
        if (state == init_data && claimed && !wr_q)
            rdata <= bus.ad;                   // target drives memory word here
    end

    // drive towards the merge with strobes high and zeros when idle
    assign port.req_n   = (state != init_req);
    assign port.frame_n = (state != init_addr);
    assign port.irdy_n  = (state != init_data);
    assign port.ad      = (state == init_addr)          ? addr_q  :
                          (state == init_data && wr_q)  ? wdata_q : '0;
    assign port.cbe     = (state == init_addr) ? cmd : cmd_read;

    assign done  = (state == init_turn) && !aborted;
    assign abort = (state == init_turn) && aborted;

    // irdy never from idle, and no other address phase during our data phase
    a_irdy_in_txn: assert property (@(posedge clk) disable iff (!rst_n)
        !port.irdy_n |-> (state != init_idle) && bus.frame_n);

endmodule

//--- logic/pci_target.sv
`timescale 1ns/1ps

module pci_target import pci_pkg::*; #(
    parameter addr_t DEV_ADDR = DEV_ADDR_BASE
) (
    input  logic       clk,
    input  logic       rst_n,
    pci_bus_if.target  bus,
    output logic       trdy_n,
    output logic       devsel_n,
    output word_t      ad_out      // zero unless answering a read
);

    word_t mem [MEM_WORDS];
    ptr_t  wr_ptr;        // next slot for a write
    ptr_t  rd_ptr;        // next slot for a read
    logic  resp_q;        // claimed so respond this cycle
    logic  resp_wr_q;     // claimed transfer is a write
    logic  hit;
    logic  xfer;

    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_t n;
        n = (p == ptr_t'(MEM_WORDS - 1)) ? '0 : p + 1'b1;   // wrap 9 -> 0
        return n;
    endfunction

    // address phase aimed at us
    assign hit  = !bus.frame_n && (bus.ad == DEV_ADDR);
    // data moves at the edge ending the response cycle
    assign xfer = resp_q && !bus.irdy_n;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            resp_q    <= 1'b0;
            resp_wr_q <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end
        else
        begin
            resp_q <= hit;                     // exactly one cycle at A+1
            if (hit)
                resp_wr_q <= (bus.cbe == cmd_write);
            if (xfer && resp_wr_q)
            begin
                mem[wr_ptr] <= bus.ad;
                wr_ptr      <= ptr_inc(wr_ptr);
            end
            else if (xfer)
                rd_ptr <= ptr_inc(rd_ptr);
        end
    end

    assign devsel_n = !resp_q;
    assign trdy_n   = !resp_q;                 // always ready without wait states
    assign ad_out   = (resp_q && !resp_wr_q) ? mem[rd_ptr] : '0;

    // ready only with devsel and inside the initiator's data phase
    a_trdy_in_data: assert property (@(posedge clk) disable iff (!rst_n)
        !trdy_n |-> !devsel_n && !bus.irdy_n);

endmodule

//--- logic/pci_system.sv
`timescale 1ns/1ps

module pci_system import pci_pkg::*; #(
    parameter int NUM_DEV = 2            // 2..5 devices
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [NUM_DEV-1:0] force_req,
    input  logic [NUM_DEV-1:0] rw,
    input  addr_t              contact_addr [NUM_DEV],
    input  word_t              wdata [NUM_DEV],
    output logic [NUM_DEV-1:0] done,
    output logic [NUM_DEV-1:0] abort,
    output word_t              rdata [NUM_DEV],
    output logic [NUM_DEV-1:0] bus_owner_n    // gnt_n vector
);

    logic [NUM_DEV-1:0] tgt_trdy_n;
    logic [NUM_DEV-1:0] tgt_devsel_n;
    word_t              tgt_ad [NUM_DEV];

    pci_bus_if  bus ();                  // merged bus
    pci_init_if init_if [NUM_DEV] ();    // per-initiator drive

    for (genvar i = 0; i < NUM_DEV; i++) begin : g_dev
        pci_initiator i_initiator (
            .clk          (clk),
            .rst_n        (rst_n),
            .force_req    (force_req[i]),
            .rw           (rw[i]),
            .contact_addr (contact_addr[i]),
            .wdata        (wdata[i]),
            .bus          (bus.initiator),
            .port         (init_if[i].initiator),
            .done         (done[i]),
            .abort        (abort[i]),
            .rdata        (rdata[i])
        );

        // device i sits at base + i
        pci_target #(
            .DEV_ADDR (addr_t'(DEV_ADDR_BASE + i))
        ) i_target (
            .clk      (clk),
            .rst_n    (rst_n),
            .bus      (bus.target),
            .trdy_n   (tgt_trdy_n[i]),
            .devsel_n (tgt_devsel_n[i]),
            .ad_out   (tgt_ad[i])
        );
    end

    pci_central #(
        .NUM_DEV (NUM_DEV)
    ) i_central (
        .clk          (clk),
        .rst_n        (rst_n),
        .init         (init_if),
        .tgt_trdy_n   (tgt_trdy_n),
        .tgt_devsel_n (tgt_devsel_n),
        .tgt_ad       (tgt_ad),
        .bus          (bus.central),
        .gnt_vec_n    (bus_owner_n)
    );

endmodule

//--- bench/pci_system_tb.sv
`timescale 1ns/1ps

module pci_system_tb import pci_pkg::*; ();

    localparam int NUM_DEV   = 2;
    localparam int MAX_TESTS = 64;
    localparam int COLS      = 6;              // words per stimulus entry

    // entry kinds, first column of the stimulus file
    localparam word_t KIND_WRITE = 32'h1;
    localparam word_t KIND_READ  = 32'h2;
    localparam word_t KIND_ABORT = 32'h3;
    localparam word_t KIND_PAIR  = 32'h4;

    logic               clk;
    logic               rst_n;
    logic [NUM_DEV-1:0] force_req;
    logic [NUM_DEV-1:0] rw;
    addr_t              contact_addr [NUM_DEV];
    word_t              wdata [NUM_DEV];
    logic [NUM_DEV-1:0] done;
    logic [NUM_DEV-1:0] abort;
    word_t              rdata [NUM_DEV];
    logic [NUM_DEV-1:0] bus_owner_n;

    word_t stim [MAX_TESTS*COLS];              // flat table, COLS words per test
    word_t model_mem [NUM_DEV][MEM_WORDS];     // expected target memories
    int    model_wr [NUM_DEV];                 // expected write pointers
    int    model_rd [NUM_DEV];                 // expected read pointers
    int    num_tests;
    int    cycles      = 0;
    int    cycle_limit = 0;                    // armed once the file is read

    pci_system #(
        .NUM_DEV (NUM_DEV)
    ) i_pci_system (
        .clk          (clk),
        .rst_n        (rst_n),
        .force_req    (force_req),
        .rw           (rw),
        .contact_addr (contact_addr),
        .wdata        (wdata),
        .done         (done),
        .abort        (abort),
        .rdata        (rdata),
        .bus_owner_n  (bus_owner_n)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;                // 20 ns period
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
            stop_run($sformatf("timeout, no result after %0d cycles", cycles));
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp)
        else
            stop_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    // nothing running, nobody owns the bus
    task automatic check_idle();
        check_value("done", word_t'(done), '0);
        check_value("abort", word_t'(abort), '0);
        check_value("bus_owner_n", word_t'(bus_owner_n), word_t'({NUM_DEV{1'b1}}));
    endtask

    // target index for an address, -1 when unmapped
    function automatic int target_of(input addr_t addr);
        int t;
        t = -1;
        if (addr >= DEV_ADDR_BASE && addr < DEV_ADDR_BASE + NUM_DEV)
            t = int'(addr - DEV_ADDR_BASE);
        return t;
    endfunction

    task automatic model_write(input int t, input word_t wd);
        model_mem[t][model_wr[t]] = wd;
        model_wr[t] = (model_wr[t] + 1) % MEM_WORDS;   // wraps after MEM_WORDS
    endtask

    task automatic model_read(input int t, output word_t wd);
        wd = model_mem[t][model_rd[t]];
        model_rd[t] = (model_rd[t] + 1) % MEM_WORDS;
    endtask

    // raise force_req, wait for done or abort, drop it again
    task automatic do_transfer(input int dev, input logic wr, input addr_t addr,
                               input word_t wd, output logic got_done, output logic got_abort);
        @(negedge clk);
        force_req[dev]    = 1'b1;
        rw[dev]           = wr;
        contact_addr[dev] = addr;
        wdata[dev]        = wd;
        do
            @(negedge clk);
        while (!done[dev] && !abort[dev]);
        got_done       = done[dev];
        got_abort      = abort[dev];
        force_req[dev] = 1'b0;                 // turn cycle, idle comes next
    endtask

    task automatic single_test(input word_t kind, input int dev, input addr_t addr,
                               input word_t wd, input logic use_exp, input word_t exp);
        int    t;
        logic  wr;
        logic  got_done;
        logic  got_abort;
        word_t model_exp;
        t  = target_of(addr);
        wr = (kind != KIND_READ);              // abort entries try a write
        do_transfer(dev, wr, addr, wd, got_done, got_abort);
        check_value($sformatf("done[%0d]", dev), word_t'(got_done), word_t'(kind != KIND_ABORT));
        check_value($sformatf("abort[%0d]", dev), word_t'(got_abort), word_t'(kind == KIND_ABORT));
        if (kind == KIND_WRITE)
            model_write(t, wd);
        else if (kind == KIND_READ)
        begin
            model_read(t, model_exp);
            check_value($sformatf("rdata[%0d]", dev), rdata[dev], model_exp);
            if (use_exp)
                check_value($sformatf("rdata[%0d]", dev), rdata[dev], exp);
        end
    endtask

    // both devices write the same target, same falling edge
    task automatic pair_test(input addr_t addr, input word_t wd0, input word_t wd1);
        int                 first;
        int                 d;
        logic [NUM_DEV-1:0] fin;
        @(negedge clk);
        force_req       = '1;
        rw              = '1;
        contact_addr[0] = addr;
        contact_addr[1] = addr;
        wdata[0]        = wd0;
        wdata[1]        = wd1;
        first           = -1;
        fin             = '0;
        while (fin != '1)
        begin
            @(negedge clk);
            check_value("abort", word_t'(abort), '0);
            for (d = 0; d < NUM_DEV; d++)
            begin
                if (done[d] && !fin[d])
                begin
                    fin[d]       = 1'b1;
                    force_req[d] = 1'b0;
                    if (first < 0)
                        first = d;
                end
            end
        end
        check_value("index of first done", word_t'(first), 32'd1);   // highest index wins
        model_write(target_of(addr), wd1);
        model_write(target_of(addr), wd0);
    endtask

    initial
    begin
        word_t kind;
        int    dev;
        addr_t addr;
        word_t mode;
        word_t wd;
        void'($urandom(32'hd66c_4665));
        rst_n     = 1'b0;
        force_req = '0;
        rw        = '0;
        for (int d = 0; d < NUM_DEV; d++)
        begin
            contact_addr[d] = '0;
            wdata[d]        = '0;
            model_wr[d]     = 0;
            model_rd[d]     = 0;
            for (int w = 0; w < MEM_WORDS; w++)
                model_mem[d][w] = '0;           // memories come out of reset zeroed
        end
        for (int i = 0; i < MAX_TESTS*COLS; i++)
            stim[i] = '0;                       // kind 0 marks the end
        $readmemh("bench/pci_stimulus.txt", stim);
        num_tests = 0;
        while (num_tests < MAX_TESTS && stim[num_tests*COLS] != '0)
            num_tests++;
        assert (num_tests > 0)
        else
            stop_run("no entries read from bench/pci_stimulus.txt");
        cycle_limit = num_tests * 40;

        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            if (i == 5)
                rst_n = 1'b1;                   // 5 cycles of reset
            check_idle();
        end

        for (int n = 0; n < num_tests; n++)
        begin
            kind = stim[n*COLS];
            dev  = int'(stim[n*COLS+1]);
            addr = stim[n*COLS+2];
            mode = stim[n*COLS+3];
            wd   = (mode != '0 && kind != KIND_READ) ? $urandom : stim[n*COLS+4];
            if (kind == KIND_PAIR)
                pair_test(addr, wd, stim[n*COLS+5]);
            else if (kind == KIND_WRITE || kind == KIND_READ || kind == KIND_ABORT)
                single_test(kind, dev, addr, wd, mode == '0, stim[n*COLS+5]);
            else
                stop_run($sformatf("unknown entry kind %0h in the stimulus file", kind));
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- bench/pci_stimulus.txt
// kind dev addr mode wdata exp   kind 1 write, 2 read, 3 abort, 4 pair
// mode 1 random wdata or model-only read check, pair exp is device 1 word
1 0 11 0 cafe0001 0   // device 0 writes target 1
1 0 11 0 cafe0002 0
1 0 11 0 cafe0003 0
2 0 11 0 0 cafe0001   // read back in write order
2 1 11 0 0 cafe0002
2 0 11 0 0 cafe0003
1 1 10 1 0 0   // eleven random writes into target 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
1 1 10 1 0 0
2 1 10 1 0 0   // eleven reads, both pointers wrap
2 0 10 1 0 0
2 1 10 1 0 0
2 0 10 1 0 0
2 1 10 1 0 0
2 0 10 1 0 0
2 1 10 1 0 0
2 0 10 1 0 0
2 1 10 1 0 0
2 0 10 1 0 0
2 1 10 1 0 0
3 0 40 0 dead0000 0   // nobody answers 0x40
4 0 11 0 5a5a0000 a5a50001   // both at once, device 1 first
2 0 11 0 0 a5a50001
2 1 11 0 0 5a5a0000
2 0 10 1 0 0   // target 0 untouched by the abort

//--- sources.f
logic/pci_pkg.sv
logic/pci_bus_if.sv
logic/pci_init_if.sv
logic/pci_central.sv
logic/pci_initiator.sv
logic/pci_target.sv
logic/pci_system.sv
bench/pci_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module pci_system_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vpci_system_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
